//--- glb.f
logic/glb_pkg.sv
logic/glb_reg_pkg.sv
logic/sram_model.sv
logic/sram_wrap.sv
logic/buf_ctrl.sv
logic/buf_regs.sv
logic/glb_top.sv
tests/glb_chk.sv
tests/glb_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module glb_tb -f glb.f -o glb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/glb_sim > sim.log 2>&1 || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

//--- tests/glb_tb.sv
module glb_tb;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [glb_reg_pkg::PADDR_W-1:0] paddr;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [glb_reg_pkg::PDATA_W-1:0] pwdata;
    logic [glb_reg_pkg::PDATA_W-1:0] prdata;
    logic                            pready;
    logic                            pslverr;
    logic                            in_valid;
    logic                            in_ready;
    logic [glb_pkg::DATA_W-1:0]      in_data;
    logic                            out_valid;
    logic                            out_ready;
    logic [glb_pkg::DATA_W-1:0]      out_data;
    logic                            irq;

    logic [31:0]                lfsr = 32'hf19a;
    logic [glb_pkg::DATA_W-1:0] sent_q[$];
    int                         out_idx = 0;
    int                         lvl_m = 0;    // SRAM words not yet read out.
    int                         lvl_prev = 0;
    int                         peak_m = 0;
    logic                       ov_m = 1'b0;
    int                         th_m = 0;
    logic                       irq_chk = 1'b1;
    int                         errors = 0;
    int                         timeouts = 0;
    logic [31:0]                th;

    glb_top DUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // FIFO order: output word i is input word i since the last flush.
    function automatic logic [glb_pkg::DATA_W-1:0] expected_word(input int idx);
        return sent_q[idx];
    endfunction

    function automatic logic expected_irq(input int lvl, input int thr);
        return (thr != 0) && (lvl >= thr);
    endfunction

    function automatic logic [31:0] status_word(input int lvl);
        logic [31:0] w;
        w = 32'(lvl);
        w[8] = (lvl == 0);
        w[9] = (lvl == glb_pkg::DEPTH);
        return w;
    endfunction

    task automatic report_fail(input string what, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic finish_run();
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: %s did not finish in time", $time, what);
        finish_run();
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp, input logic exp_err);
        int          t;
        logic [31:0] got;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        t = 0;
        while (!pready && t < 16) begin
            @(negedge clk);
            t++;
        end
        if (!pready) begin
            stop_on_timeout("APB access");
        end
        @(posedge clk);
        got = prdata;
        if (pslverr !== exp_err) report_fail("pslverr", 32'(pslverr), 32'(exp_err));
        if (!wr && got !== exp) report_fail("prdata", got, exp);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Sends n words and, with drain set, takes words until all are out.
    task automatic run_stream(input int n, input logic gaps, input logic drain);
        int   sent;
        int   t;
        logic took;
        sent = 0;
        t    = 0;
        took = 1'b0;
        @(negedge clk);
        while ((sent < n || (drain && out_idx < sent_q.size())) && t < 50 * n + 200) begin
            if (took) in_valid = 1'b0;
            if (sent < n && !in_valid && (!gaps || take_bits(2) != 0)) begin
                in_valid = 1'b1;
                in_data  = take_bits(32);
            end
            out_ready = drain && (!gaps || take_bits(1) != 0);
            @(posedge clk);
            took = in_valid && in_ready;
            if (took) sent++;
            t++;
            @(negedge clk);
        end
        in_valid  = 1'b0;
        out_ready = 1'b0;
        if (sent < n || (drain && out_idx < sent_q.size())) begin
            stop_on_timeout("stream transfer");
        end
    endtask

    always @(posedge clk) begin : compare_outputs
        logic in_fire;
        logic out_fire;
        logic apb_wr;
        logic rd;
        if (rst_n) begin
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            apb_wr   = psel && penable && pwrite;
            if (out_valid !== ov_m) report_fail("out_valid", 32'(out_valid), 32'(ov_m));
            if (irq_chk && irq !== expected_irq(lvl_prev, th_m)) begin
                report_fail("irq", 32'(irq), 32'(expected_irq(lvl_prev, th_m)));
            end
            if (in_fire) sent_q.push_back(in_data);
            if (out_fire) begin
                if (out_idx >= sent_q.size()) begin
                    errors++;
                    $display("Output word at %0t arrived with none left to expect", $time);
                end else if (out_data !== expected_word(out_idx)) begin
                    report_fail("out_data", out_data, expected_word(out_idx));
                end
                out_idx <= out_idx + 1;
            end
            lvl_prev <= lvl_m;
            if (apb_wr && paddr == glb_reg_pkg::REG_PEAK) begin
                peak_m <= lvl_m;
            end else if (lvl_m > peak_m) begin
                peak_m <= lvl_m;
            end
            if (apb_wr && paddr == glb_reg_pkg::REG_CTRL && pwdata[1]) begin
                lvl_m   <= 0;
                ov_m    <= 1'b0;
                out_idx <= sent_q.size(); // Flushed words are dropped.
            end else begin
                rd = (lvl_m != 0) && (!ov_m || out_fire);
                lvl_m <= lvl_m + int'(in_fire) - int'(rd);
                if (rd) ov_m <= 1'b1;
                else if (out_fire) ov_m <= 1'b0;
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b0 || irq !== 1'b0) begin
            errors++;
            $display("FAIL at %0t: outputs not idle after reset", $time);
        end
        apb_xfer(1'b0, glb_reg_pkg::REG_STATUS, 0, status_word(0), 1'b0);
        apb_xfer(1'b0, glb_reg_pkg::REG_CTRL, 0, 0, 1'b0);
        apb_xfer(1'b1, glb_reg_pkg::REG_CTRL, 1, 0, 1'b0);
        run_stream(300, 1'b1, 1'b1);
        run_stream(65, 1'b0, 1'b0); // One word sits in the output stage.
        @(negedge clk);
        if (in_ready !== 1'b0) report_fail("in_ready when full", 32'(in_ready), 0);
        apb_xfer(1'b0, glb_reg_pkg::REG_STATUS, 0, status_word(glb_pkg::DEPTH), 1'b0);
        run_stream(0, 1'b0, 1'b1);
        th = take_bits(6);
        if (th == 0) th = 1;
        irq_chk = 1'b0;
        apb_xfer(1'b1, glb_reg_pkg::REG_THRESH, th, 0, 1'b0);
        th_m = int'(th);
        @(negedge clk);
        irq_chk = 1'b1;
        run_stream(65, 1'b0, 1'b0);
        run_stream(100, 1'b1, 1'b1);
        @(negedge clk);
        apb_xfer(1'b0, glb_reg_pkg::REG_PEAK, 0, 32'(peak_m), 1'b0);
        apb_xfer(1'b1, glb_reg_pkg::REG_PEAK, 0, 0, 1'b0);
        run_stream(10, 1'b0, 1'b0);
        @(negedge clk);
        apb_xfer(1'b0, glb_reg_pkg::REG_PEAK, 0, 32'(peak_m), 1'b0);
        apb_xfer(1'b1, glb_reg_pkg::REG_CTRL, 3, 0, 1'b0);
        if (out_valid !== 1'b0) report_fail("out_valid after flush", 32'(out_valid), 0);
        apb_xfer(1'b0, glb_reg_pkg::REG_STATUS, 0, status_word(0), 1'b0);
        run_stream(20, 1'b1, 1'b1);
        apb_xfer(1'b1, 8'h10, 32'h0000_0000, 0, 1'b1);
        apb_xfer(1'b0, 8'h10, 0, 0, 1'b1);
        apb_xfer(1'b0, glb_reg_pkg::REG_CTRL, 0, 1, 1'b0);
        apb_xfer(1'b0, glb_reg_pkg::REG_THRESH, 0, th, 1'b0);
        apb_xfer(1'b0, glb_reg_pkg::REG_PEAK, 0, 32'(peak_m), 1'b0);
        finish_run();
    end

endmodule

//--- tests/glb_chk.sv
module glb_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       psel,
    input logic                       pready,
    input logic                       in_ready,
    input logic                       full,
    input logic                       out_valid,
    input logic                       out_ready,
    input logic [glb_pkg::DATA_W-1:0] out_data
);

    // A stalled output word must not change.
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("out_data changed while the sink stalled");

    full_block: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> !in_ready)
        else $error("in_ready high while the buffer is full");

    apb_ready: assert property (@(posedge clk) disable iff (!rst_n)
        psel |-> pready)
        else $error("pready low during an APB transfer");

endmodule

bind glb_top glb_chk u_glb_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .pready    (pready),
    .in_ready  (in_ready),
    .full      (stat.full),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

//--- logic/glb_top.sv
module glb_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [glb_reg_pkg::PADDR_W-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [glb_reg_pkg::PDATA_W-1:0] pwdata,
    output logic [glb_reg_pkg::PDATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [glb_pkg::DATA_W-1:0]      in_data,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [glb_pkg::DATA_W-1:0]      out_data,
    output logic                            irq
);

    glb_reg_pkg::glb_cfg_t  cfg;
    glb_reg_pkg::glb_stat_t stat;
    glb_pkg::sram_req_t     req;

    buf_regs u_buf_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .stat    (stat),
        .cfg     (cfg),
        .irq     (irq)
    );

    buf_ctrl u_buf_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .stat      (stat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .req       (req)
    );

    sram_wrap u_sram_wrap (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .data_out (out_data) // Held read data is the output stage.
    );

endmodule

//--- logic/buf_regs.sv
module buf_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [glb_reg_pkg::PADDR_W-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [glb_reg_pkg::PDATA_W-1:0] pwdata,
    output logic [glb_reg_pkg::PDATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  glb_reg_pkg::glb_stat_t          stat,
    output glb_reg_pkg::glb_cfg_t           cfg,
    output logic                            irq
);

    glb_reg_pkg::reg_addr_e      addr;
    logic                        access;
    logic                        mapped;
    logic                        wr_ctrl;
    logic                        wr_thresh;
    logic                        wr_peak;
    logic                        enable;
    logic [glb_pkg::LEVEL_W-1:0] thresh;
    logic [glb_pkg::LEVEL_W-1:0] peak;

    assign addr   = glb_reg_pkg::reg_addr_e'(paddr);
    assign access = psel & penable;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (addr)
            glb_reg_pkg::REG_CTRL: begin
                prdata[glb_reg_pkg::CTRL_EN_BIT] = enable;
            end
            glb_reg_pkg::REG_STATUS: begin
                prdata[glb_pkg::LEVEL_W-1:0]        = stat.level;
                prdata[glb_reg_pkg::STAT_EMPTY_BIT] = stat.empty;
                prdata[glb_reg_pkg::STAT_FULL_BIT]  = stat.full;
            end
            glb_reg_pkg::REG_THRESH: prdata[glb_pkg::LEVEL_W-1:0] = thresh;
            glb_reg_pkg::REG_PEAK:   prdata[glb_pkg::LEVEL_W-1:0] = peak;
            default:                 mapped = 1'b0; // Unmapped reads as zero.
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;

    assign wr_ctrl   = access & pwrite & (addr == glb_reg_pkg::REG_CTRL);
    assign wr_thresh = access & pwrite & (addr == glb_reg_pkg::REG_THRESH);
    assign wr_peak   = access & pwrite & (addr == glb_reg_pkg::REG_PEAK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
            thresh <= '0;
            peak   <= '0;
            irq    <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                enable <= pwdata[glb_reg_pkg::CTRL_EN_BIT];
            end
            if (wr_thresh) begin
                thresh <= pwdata[glb_pkg::LEVEL_W-1:0];
            end
            if (wr_peak || stat.level > peak) begin
                peak <= stat.level; // Restart from current level.
            end
            irq <= (cfg.thresh != '0) && (stat.level >= cfg.thresh);
        end
    end

    assign cfg.enable = enable;
    assign cfg.flush  = wr_ctrl & pwdata[glb_reg_pkg::CTRL_FLUSH_BIT]; // Acts at access edge.
    assign cfg.thresh = thresh;

endmodule

//--- logic/buf_ctrl.sv
module buf_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  glb_reg_pkg::glb_cfg_t      cfg,
    output glb_reg_pkg::glb_stat_t     stat,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [glb_pkg::DATA_W-1:0] in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output glb_pkg::sram_req_t         req
);

    logic [glb_pkg::ADDR_W-1:0]  wr_ptr;
    logic [glb_pkg::ADDR_W-1:0]  rd_ptr;
    logic [glb_pkg::LEVEL_W-1:0] level;
    logic                        full;
    logic                        in_fire;
    logic                        out_fire;
    logic                        rd_issue;

    assign full     = level == glb_pkg::LEVEL_W'(glb_pkg::DEPTH);
    assign in_ready = cfg.enable & ~full & ~cfg.flush;
    assign in_fire  = in_valid & in_ready;
    assign out_fire = out_valid & out_ready;

    // Refill the output stage when it is empty or being drained.
    assign rd_issue = (level != '0) & (~out_valid | out_ready) & ~cfg.flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            out_valid <= 1'b0;
        end else if (cfg.flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH.
            end
            if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + glb_pkg::LEVEL_W'(in_fire) - glb_pkg::LEVEL_W'(rd_issue);
            if (rd_issue) begin
                out_valid <= 1'b1; // Wrapper data lands with it.
            end else if (out_fire) begin
                out_valid <= 1'b0;
            end
        end
    end

    assign req.read_en  = rd_issue;
    assign req.write_en = in_fire;
    assign req.addr_r   = rd_ptr;
    assign req.addr_w   = wr_ptr;
    assign req.data_in  = in_data;

    assign stat.level = level;
    assign stat.empty = level == '0;
    assign stat.full  = full;

endmodule

//--- logic/sram_wrap.sv
module sram_wrap (
    input  logic                       clk,
    input  logic                       rst_n,
    input  glb_pkg::sram_req_t         req,
    output logic [glb_pkg::DATA_W-1:0] data_out
);

    logic                       cs_n;
    logic                       read_en_d;
    logic [glb_pkg::DATA_W-1:0] q;
    logic [glb_pkg::DATA_W-1:0] q_hold;

    assign cs_n = ~req.read_en & ~req.write_en; // Active-low chip select.

    sram_model u_sram_model (
        .clk      (clk),
        .read_en  (req.read_en & ~cs_n),
        .write_en (req.write_en & ~cs_n),
        .addr_r   (req.addr_r),
        .addr_w   (req.addr_w),
        .data_in  (req.data_in),
        .data_out (q)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_en_d <= 1'b0;
        end else begin
            read_en_d <= req.read_en;
        end
    end

    // Locks the last read word until the next read.
    always_ff @(posedge clk) begin
        if (read_en_d) begin
            q_hold <= q;
        end
    end

    assign data_out = read_en_d ? q : q_hold;

endmodule

//--- logic/sram_model.sv
module sram_model (
    input  logic                       clk,
    input  logic                       read_en,
    input  logic                       write_en,
    input  logic [glb_pkg::ADDR_W-1:0] addr_r,
    input  logic [glb_pkg::ADDR_W-1:0] addr_w,
    input  logic [glb_pkg::DATA_W-1:0] data_in,
    output logic [glb_pkg::DATA_W-1:0] data_out
);

    logic [glb_pkg::DATA_W-1:0] mem [glb_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr_w] <= data_in;
        end
    end

    // Q keeps its value between reads, as on the macro.
    always_ff @(posedge clk) begin
        if (read_en) begin
            data_out <= mem[addr_r];
        end
    end

endmodule

//--- logic/glb_reg_pkg.sv
package glb_reg_pkg;

    localparam int PADDR_W = 8;
    localparam int PDATA_W = 32;

    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_FLUSH_BIT = 1; // Write-one, reads as zero.
    localparam int STAT_EMPTY_BIT = 8;
    localparam int STAT_FULL_BIT  = 9;

    typedef enum logic [PADDR_W-1:0] {
        REG_CTRL   = 8'h00,
        REG_STATUS = 8'h04,
        REG_THRESH = 8'h08,
        REG_PEAK   = 8'h0C
    } reg_addr_e;

    typedef struct packed {
        logic                        enable;
        logic                        flush;  // Single-cycle pulse.
        logic [glb_pkg::LEVEL_W-1:0] thresh;
    } glb_cfg_t;

    typedef struct packed {
        logic [glb_pkg::LEVEL_W-1:0] level;
        logic                        empty;
        logic                        full;
    } glb_stat_t;

endpackage

//--- logic/glb_pkg.sv
package glb_pkg;

    localparam int DEPTH   = 64;
    localparam int ADDR_W  = $clog2(DEPTH);
    localparam int DATA_W  = 32;
    localparam int LEVEL_W = ADDR_W + 1; // Counts 0 to DEPTH.

    // Request from the buffer controller to the SRAM wrapper.
    typedef struct packed {
        logic              read_en;
        logic              write_en;
        logic [ADDR_W-1:0] addr_r;
        logic [ADDR_W-1:0] addr_w;
        logic [DATA_W-1:0] data_in;
    } sram_req_t;

endpackage
